//--- audio_filter_config.svh
//////////////////////////////
// Constants of the audio filter block
// Include wherever pacing, widths or coefficients are needed
//////////////////////////////

`ifndef AUDIO_FILTER_CONFIG_SVH
`define AUDIO_FILTER_CONFIG_SVH

// Clocks per output sample, about 46.9 kHz at the core clock
`define AF_SAMPLE_DIV 256

// Data and coefficient widths
`define AF_SAMPLE_W 16
`define AF_DAC_W 8
`define AF_COEFF_W 22

// Fraction bits of every coefficient
`define AF_COEFF_SCALE 15

// First speech section, f0 near 3.47 kHz
`define AF_SP1_B1 1318
`define AF_SP1_B2 2636
`define AF_SP1_B3 1318
`define AF_SP1_A2 (-44251)
`define AF_SP1_A3 16754

// Second speech section, f0 near 3.33 kHz
`define AF_SP2_B1 1226
`define AF_SP2_B2 2453
`define AF_SP2_B3 1226
`define AF_SP2_A2 (-45163)
`define AF_SP2_A3 17301

// One-pole smoother after the DAC boxcar
`define AF_DAC_B1 16701
`define AF_DAC_B2 16701
`define AF_DAC_A2 634

`endif

//--- audio_filter_pkg.sv
//////////////////////////////
// Shared types of the audio filter block
// Imported by every module of the design
//////////////////////////////

`include "audio_filter_config.svh"

package audio_filter_pkg;

	// Signed audio sample, centred on zero
	typedef logic signed [`AF_SAMPLE_W-1:0] sample_t;

	// Unsigned audio sample, centred on mid scale
	typedef logic [`AF_SAMPLE_W-1:0] usample_t;

	// Raw sound DAC code
	typedef logic [`AF_DAC_W-1:0] dac_t;

	// Fixed-point filter coefficient
	typedef logic signed [`AF_COEFF_W-1:0] coeff_t;

	// Coefficient set of one second-order section
	// b terms feed forward, a terms feed back
	typedef struct packed {
		coeff_t b1;
		coeff_t b2;
		coeff_t b3;
		coeff_t a2;
		coeff_t a3;
	} biquad_coeff_t;

	// Speech source chosen by the mixer
	typedef enum logic {
		SPEECH_RAW      = 1'b0,
		SPEECH_FILTERED = 1'b1
	} speech_mode_e;

	// Clip limits of a signed sample
	localparam sample_t SAMPLE_MAX = {1'b0, {(`AF_SAMPLE_W-1){1'b1}}};
	localparam sample_t SAMPLE_MIN = {1'b1, {(`AF_SAMPLE_W-1){1'b0}}};

	// Offset between the unsigned and signed formats
	localparam usample_t SAMPLE_BIAS = {1'b1, {(`AF_SAMPLE_W-1){1'b0}}};

endpackage

//--- iir_biquad.sv
//////////////////////////////
// Direct-form-I second-order low-pass section with output clipping
// Steps once per sample strobe, coefficients come in as a struct
//////////////////////////////

`include "audio_filter_config.svh"

module iir_biquad import audio_filter_pkg::*; (
	input  logic          clk_sys,
	input  logic          reset,
	input  logic          sample_tick,
	input  biquad_coeff_t coeff,
	input  sample_t       x,
	output sample_t       y
);

	// Product width plus headroom for five terms
	localparam int ACC_W = `AF_SAMPLE_W + `AF_COEFF_W + 3;

	// Input and output history
	sample_t x1;
	sample_t x2;
	sample_t y1;
	sample_t y2;

	logic signed [ACC_W-1:0] acc;
	logic signed [ACC_W-1:0] acc_shr;
	sample_t                 y_next;

	//////////////////////////////
	// Difference equation
	//////////////////////////////

	// Feed-forward terms minus feedback terms
	// All operands signed, so everything widens to ACC_W first
	always_comb begin
		acc = $signed(coeff.b1) * x
			+ $signed(coeff.b2) * x1
			+ $signed(coeff.b3) * x2
			- $signed(coeff.a2) * y1
			- $signed(coeff.a3) * y2;
	end

	// Drop the fraction bits, sign kept
	assign acc_shr = acc >>> `AF_COEFF_SCALE;

	// Clip to the sample range
	always_comb begin
		if (acc_shr > SAMPLE_MAX) begin
			y_next = SAMPLE_MAX;
		end else if (acc_shr < SAMPLE_MIN) begin
			y_next = SAMPLE_MIN;
		end else begin
			y_next = acc_shr[`AF_SAMPLE_W-1:0];
		end
	end

	//////////////////////////////
	// History registers
	//////////////////////////////

	// Shift both delay lines on each strobe
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			x1 <= '0;
			x2 <= '0;
			y1 <= '0;
			y2 <= '0;
		end else if (sample_tick) begin
			x1 <= x;
			x2 <= x1;
			y1 <= y_next;
			y2 <= y1;
		end
	end

	// Newest output is the section result
	assign y = y1;

endmodule

//--- speech_path.sv
//////////////////////////////
// Speech chain: re-centre, two low-pass sections, four times boost
// Paced by the shared strobe, both raw and filtered results leave
//////////////////////////////

`include "audio_filter_config.svh"

module speech_path import audio_filter_pkg::*; (
	input  logic     clk_sys,
	input  logic     reset,
	input  logic     sample_tick,
	input  usample_t speech_in,
	output usample_t speech_raw,
	output usample_t speech_filtered
);

	// Gain of four as a left shift
	localparam int BOOST_SHIFT = 2;

	// Coefficient sets of the two cascaded sections
	localparam biquad_coeff_t SP1_COEFF = '{
		b1: coeff_t'(`AF_SP1_B1),
		b2: coeff_t'(`AF_SP1_B2),
		b3: coeff_t'(`AF_SP1_B3),
		a2: coeff_t'(`AF_SP1_A2),
		a3: coeff_t'(`AF_SP1_A3)
	};
	localparam biquad_coeff_t SP2_COEFF = '{
		b1: coeff_t'(`AF_SP2_B1),
		b2: coeff_t'(`AF_SP2_B2),
		b3: coeff_t'(`AF_SP2_B3),
		a2: coeff_t'(`AF_SP2_A2),
		a3: coeff_t'(`AF_SP2_A3)
	};

	usample_t speech_reg;
	sample_t  speech_c;
	sample_t  stage1_y;
	sample_t  stage2_y;

	logic signed [`AF_SAMPLE_W+BOOST_SHIFT-1:0] boosted;
	sample_t                                    boost_sat;

	// Speech word captured once per sample
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			speech_reg <= '0;
		end else if (sample_tick) begin
			speech_reg <= speech_in;
		end
	end

	// Unsigned to signed around mid scale
	assign speech_c = sample_t'(speech_reg - SAMPLE_BIAS);

	// First section, acts one strobe after capture
	iir_biquad stage1_inst (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.sample_tick (sample_tick),
		.coeff       (SP1_COEFF),
		.x           (speech_c),
		.y           (stage1_y)
	);

	// Second section, one strobe later again
	iir_biquad stage2_inst (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.sample_tick (sample_tick),
		.coeff       (SP2_COEFF),
		.x           (stage1_y),
		.y           (stage2_y)
	);

	// Boost and clip
	assign boosted = stage2_y <<< BOOST_SHIFT;

	always_comb begin
		if (boosted > SAMPLE_MAX) begin
			boost_sat = SAMPLE_MAX;
		end else if (boosted < SAMPLE_MIN) begin
			boost_sat = SAMPLE_MIN;
		end else begin
			boost_sat = boosted[`AF_SAMPLE_W-1:0];
		end
	end

	// Back to unsigned for the mixer
	assign speech_filtered = usample_t'(boost_sat) + SAMPLE_BIAS;
	assign speech_raw      = speech_reg;

endmodule

//--- dac_path.sv
//////////////////////////////
// Sample pacing plus the sound DAC chain of boxcar and one-pole
// Its strobe drives every other stage of the block
//////////////////////////////

`include "audio_filter_config.svh"

module dac_path import audio_filter_pkg::*; (
	input  logic     clk_sys,
	input  logic     reset,
	input  dac_t     dac_in,
	output logic     sample_tick,
	output usample_t dac_filtered
);

	// Counter width, also the boxcar divide shift
	localparam int DIV_W = $clog2(`AF_SAMPLE_DIV);
	localparam int SUM_W = `AF_DAC_W + DIV_W;
	localparam int ACC_W = `AF_SAMPLE_W + `AF_COEFF_W + 2;

	localparam coeff_t DAC_B1 = coeff_t'(`AF_DAC_B1);
	localparam coeff_t DAC_B2 = coeff_t'(`AF_DAC_B2);
	localparam coeff_t DAC_A2 = coeff_t'(`AF_DAC_A2);

	logic [DIV_W-1:0] div_cnt;
	logic [SUM_W-1:0] box_sum;
	logic [SUM_W-1:0] box_next;
	dac_t             box_avg;

	usample_t                dac_wide;
	sample_t                 dac_x;
	sample_t                 op_x1;
	sample_t                 op_y1;
	logic signed [ACC_W-1:0] acc;
	logic signed [ACC_W-1:0] acc_shr;
	sample_t                 op_next;

	//////////////////////////////
	// Strobe and boxcar
	//////////////////////////////

	// Strobe on the last count of each period
	assign sample_tick = (div_cnt == DIV_W'(`AF_SAMPLE_DIV - 1));

	// Running sum including this clock's code
	assign box_next = box_sum + dac_in;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			div_cnt <= '0;
			box_sum <= '0;
			box_avg <= '0;
		end else if (sample_tick) begin
			div_cnt <= '0;
			box_sum <= '0;
			// Average of the whole period
			box_avg <= box_next[DIV_W +: `AF_DAC_W];
		end else begin
			div_cnt <= div_cnt + 1'b1;
			box_sum <= box_next;
		end
	end

	//////////////////////////////
	// One-pole smoother
	//////////////////////////////

	// Average into the high byte, then signed
	assign dac_wide = {box_avg, {(`AF_SAMPLE_W-`AF_DAC_W){1'b0}}};
	assign dac_x    = sample_t'(dac_wide - SAMPLE_BIAS);

	// Two feed-forward taps, one feedback tap
	assign acc     = DAC_B1 * dac_x + DAC_B2 * op_x1 - DAC_A2 * op_y1;
	assign acc_shr = acc >>> `AF_COEFF_SCALE;

	always_comb begin
		if (acc_shr > SAMPLE_MAX) begin
			op_next = SAMPLE_MAX;
		end else if (acc_shr < SAMPLE_MIN) begin
			op_next = SAMPLE_MIN;
		end else begin
			op_next = acc_shr[`AF_SAMPLE_W-1:0];
		end
	end

	// Uses the average stored on the previous strobe
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			op_x1 <= '0;
			op_y1 <= '0;
		end else if (sample_tick) begin
			op_x1 <= dac_x;
			op_y1 <= op_next;
		end
	end

	assign dac_filtered = usample_t'(op_y1) + SAMPLE_BIAS;

endmodule

//--- audio_mixer.sv
//////////////////////////////
// Mono mixer of the DAC and speech results
// Output is registered on each strobe with a one-clock valid pulse
//////////////////////////////

module audio_mixer import audio_filter_pkg::*; (
	input  logic         clk_sys,
	input  logic         reset,
	input  logic         sample_tick,
	input  speech_mode_e speech_mode,
	input  usample_t     speech_raw,
	input  usample_t     speech_filtered,
	input  usample_t     dac_filtered,
	output usample_t     audio_out,
	output logic         audio_valid
);

	usample_t                 speech_sel;
	logic [$bits(usample_t):0] mix_sum;

	// Only one title used the speech filter, so raw is selectable
	always_comb begin
		case (speech_mode)
			SPEECH_FILTERED: speech_sel = speech_filtered;
			default:         speech_sel = speech_raw;
		endcase
	end

	// Full-width sum, halved on the way out
	assign mix_sum = {1'b0, dac_filtered} + {1'b0, speech_sel};

	// Result held between strobes
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			audio_out <= '0;
		end else if (sample_tick) begin
			audio_out <= mix_sum[$bits(usample_t):1];
		end
	end

	// Valid follows the strobe by one clock
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			audio_valid <= 1'b0;
		end else begin
			audio_valid <= sample_tick;
		end
	end

endmodule

//--- audio_filter_top.sv
//////////////////////////////
// Arcade audio back end with speech and sound DAC filters
// Feed raw speech and DAC codes, read one mono sample per strobe
//////////////////////////////

module audio_filter_top import audio_filter_pkg::*; (
	input  logic         clk_sys,
	input  logic         reset,
	input  usample_t     speech_in,
	input  dac_t         dac_in,
	input  speech_mode_e speech_mode,
	output usample_t     audio_out,
	output logic         audio_valid
);

	// Shared sample strobe from the DAC path counter
	logic sample_tick;

	// Path results into the mixer
	usample_t speech_raw;
	usample_t speech_filtered;
	usample_t dac_filtered;

	// Speech chain
	speech_path speech_path_inst (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.sample_tick     (sample_tick),
		.speech_in       (speech_in),
		.speech_raw      (speech_raw),
		.speech_filtered (speech_filtered)
	);

	// DAC chain, also the pacing source
	dac_path dac_path_inst (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dac_in       (dac_in),
		.sample_tick  (sample_tick),
		.dac_filtered (dac_filtered)
	);

	// Mono output stage
	audio_mixer audio_mixer_inst (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.sample_tick     (sample_tick),
		.speech_mode     (speech_mode),
		.speech_raw      (speech_raw),
		.speech_filtered (speech_filtered),
		.dac_filtered    (dac_filtered),
		.audio_out       (audio_out),
		.audio_valid     (audio_valid)
	);

endmodule

//--- audio_filter_sva.sv
//////////////////////////////
// Output protocol checks bound into the mixer
//////////////////////////////

module audio_filter_sva import audio_filter_pkg::*; (
	input logic     clk_sys,
	input logic     reset,
	input usample_t audio_out,
	input logic     audio_valid
);

	// Failed assertions so far
	int assert_errors = 0;

	// Valid is a single-clock pulse
	valid_single_pulse: assert property (
		@(posedge clk_sys) disable iff (reset)
		audio_valid |=> !audio_valid
	) else begin
		assert_errors++;
		$error("audio_valid high on two consecutive clocks");
	end

	// Output word moves only together with its valid pulse
	out_changes_with_valid: assert property (
		@(posedge clk_sys) disable iff (reset)
		!$stable(audio_out) |-> audio_valid
	) else begin
		assert_errors++;
		$error("audio_out changed without an audio_valid pulse");
	end

	// Nothing leaves the mixer while reset is held
	no_valid_in_reset: assert property (
		@(posedge clk_sys)
		reset && $past(reset) |-> !audio_valid
	) else begin
		assert_errors++;
		$error("audio_valid high during reset");
	end

endmodule

bind audio_mixer audio_filter_sva audio_filter_sva_inst (
	.clk_sys     (clk_sys),
	.reset       (reset),
	.audio_out   (audio_out),
	.audio_valid (audio_valid)
);

//--- audio_filter_tb.sv
//////////////////////////////
// Testbench of the audio filter block driven by vectors from the input data file
// Run from the project root with the file list
//////////////////////////////

`include "audio_filter_config.svh"

module audio_filter_tb import audio_filter_pkg::*; ();

	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 10;
	localparam int VEC_COLS     = 6;
	localparam int VEC_MAX      = 64;

	logic         clk_sys;
	logic         reset;
	usample_t     speech_in;
	dac_t         dac_in;
	speech_mode_e speech_mode;
	usample_t     audio_out;
	logic         audio_valid;

	// VEC_COLS words per vector line in column order
	logic [31:0] vec_words [0:VEC_MAX*VEC_COLS-1];
	int          num_vec = 0;
	longint      total_holds = 0;
	bit          vectors_loaded = 1'b0;
	int          value_errors = 0;
	int          other_errors = 0;
	int          valid_pulses = 0;
	int          gap_cnt = 0;

	initial clk_sys = 1'b0;
	always #(CLK_PERIOD/2) clk_sys = ~clk_sys;

	audio_filter_top audio_filter_top_inst (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.speech_in   (speech_in),
		.dac_in      (dac_in),
		.speech_mode (speech_mode),
		.audio_out   (audio_out),
		.audio_valid (audio_valid)
	);

	//////////////////////////////
	// Compare tasks
	//////////////////////////////

	// Sample words within the allowed distance
	task automatic check_sample(input string name, input usample_t expected,
			input usample_t actual, input usample_t tol);
		int diff;
		diff = int'(actual) - int'(expected);
		if (diff > int'(tol) || -diff > int'(tol)) begin
			value_errors++;
			$display("FAILED %s expected %h (tolerance %h) got %h", name, expected, tol, actual);
		end
	endtask

	// Settled output of one vector in the applied speech mode
	task automatic check_mode(input speech_mode_e mode, input usample_t expected,
			input usample_t actual, input usample_t tol);
		int diff;
		diff = int'(actual) - int'(expected);
		if (diff > int'(tol) || -diff > int'(tol)) begin
			value_errors++;
			$display("FAILED audio_out expected %h (tolerance %h) got %h with speech_mode %h (%s)",
				expected, tol, actual, mode, mode.name());
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			value_errors++;
			$display("FAILED %s expected %h got %h", name, expected, actual);
		end
	endtask

	//////////////////////////////
	// Output monitor
	//////////////////////////////

	// Sampled on the falling edge away from register updates
	always @(negedge clk_sys) begin
		if (reset) begin
			check_flag("audio_valid", 1'b0, audio_valid);
			check_sample("audio_out", '0, audio_out, '0);
			gap_cnt = 0;
		end else begin
			gap_cnt++;
			if (audio_valid) begin
				// Spacing from the previous pulse
				if (valid_pulses > 0 && gap_cnt != `AF_SAMPLE_DIV) begin
					other_errors++;
					$display("Valid pulses came %0d clocks apart instead of %0d", gap_cnt,
						`AF_SAMPLE_DIV);
				end
				gap_cnt = 0;
				valid_pulses++;
			end
		end
	end

	// Block until a number of output samples went by
	task automatic wait_samples(input int count);
		repeat (count) begin
			@(negedge clk_sys);
			while (audio_valid !== 1'b1) begin
				@(negedge clk_sys);
			end
		end
	endtask

	// Drive one vector line, hold it, then check the settled output
	task automatic apply_vector(input int idx);
		int           base;
		int           hold;
		speech_mode_e mode;
		base        = idx * VEC_COLS;
		mode        = speech_mode_e'(vec_words[base+2][0]);
		hold        = int'(vec_words[base+3]);
		speech_in   = usample_t'(vec_words[base]);
		dac_in      = dac_t'(vec_words[base+1]);
		speech_mode = mode;
		wait_samples(hold);
		check_mode(mode, usample_t'(vec_words[base+4]), audio_out,
			usample_t'(vec_words[base+5]));
		@(posedge clk_sys);
		#1;
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		int v;
		int sva_errors;
		reset       = 1'b1;
		speech_in   = '0;
		dac_in      = '0;
		speech_mode = SPEECH_RAW;
		$readmemh("audio_filter_input.txt", vec_words);
		// A missing or zero hold ends the vector list
		while (num_vec < VEC_MAX && !$isunknown(vec_words[num_vec*VEC_COLS+3])
				&& vec_words[num_vec*VEC_COLS+3] != 0) begin
			total_holds += vec_words[num_vec*VEC_COLS+3];
			num_vec++;
		end
		vectors_loaded = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		for (v = 0; v < num_vec; v++) begin
			apply_vector(v);
		end
		if (num_vec == 0 || valid_pulses == 0) begin
			other_errors++;
			$display("No test vectors were run or no output sample appeared");
		end
		sva_errors = audio_filter_top_inst.audio_mixer_inst.audio_filter_sva_inst.assert_errors;
		$display("Errors: %0d value mismatches, %0d other failures, %0d assertion failures, %0d vectors, %0d samples",
			value_errors, other_errors, sva_errors, num_vec, valid_pulses);
		if (value_errors == 0 && other_errors == 0 && sva_errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	// Watchdog sized from the holds in the data file plus reset and slack
	initial begin
		longint limit;
		int     sva_errors;
		wait (vectors_loaded);
		limit = (total_holds + num_vec + RESET_CYCLES) * `AF_SAMPLE_DIV * CLK_PERIOD;
		#(limit);
		sva_errors = audio_filter_top_inst.audio_mixer_inst.audio_filter_sva_inst.assert_errors;
		$display("Timeout: the vectors did not complete within %0d time units", limit);
		$display("Errors: %0d value mismatches, %0d other failures, %0d assertion failures, %0d vectors, %0d samples",
			value_errors, other_errors + 1, sva_errors, num_vec, valid_pulses);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- audio_filter_top.f
+incdir+.
audio_filter_pkg.sv
iir_biquad.sv
speech_path.sv
dac_path.sv
audio_mixer.sv
audio_filter_top.sv
audio_filter_sva.sv
audio_filter_tb.sv

//--- Bender.yml
package:
  name: audio_filter

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - audio_filter_pkg.sv
      - iir_biquad.sv
      - speech_path.sv
      - dac_path.sv
      - audio_mixer.sv
      - audio_filter_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - audio_filter_sva.sv
      - audio_filter_tb.sv

//--- audio_filter_input.txt
// Columns: speech_in dac_in speech_mode hold expected_audio_out tolerance, all hex
// Hold counts output samples, tolerance is the allowed distance from the expected value
// Raw speech extremes with a constant DAC
0000 00 0 10 0000 0000
FFFF FF 0 10 FF7F 0000
0000 FF 0 10 7F80 0000
FFFF 00 0 10 7FFF 0000
// DAC boxcar and one-pole DC path, speech at mid scale
8000 40 0 10 6000 0000
8000 C0 0 10 A000 0000
8000 12 0 10 4900 0000
8000 80 0 10 8000 0000
// Filtered speech, small offsets boosted by four
8100 80 1 40 8200 0028
7F00 80 1 40 7E00 0028
83E8 80 1 40 87D0 0028
// Filtered speech, boost clipping in both directions
C000 80 1 40 BFFF 0000
4000 80 1 40 4000 0000
FFFF FF 1 40 FF7F 0000
0000 00 1 40 0000 0000
// Mode switch with unchanged inputs
8100 80 0 10 8080 0000
8100 80 1 40 8200 0028
8100 80 0 10 8080 0000
